/* rtl/clock_pkg.sv */
package clock_pkg;

	// --------------------
	// modes and edit positions
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_e;

	// --------------------
	// time and key bundles
	typedef struct packed {
		logic [4:0] hr;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	typedef struct packed {
		logic mode;
		logic pos;
		logic inc;
		logic alarm;
	} key_t;

	typedef logic [6:0] seg_t;	// {a, b, c, d, e, f, g}

	localparam int NUM_DIGITS = 6;

	localparam logic [5:0] MAX_SEC = 6'd59;
	localparam logic [5:0] MAX_MIN = 6'd59;
	localparam logic [4:0] MAX_HR  = 5'd23;

	// --------------------
	// segment patterns, active high
	localparam seg_t SEG_BLANK = 7'b000_0000;

	localparam seg_t SEG_DIGIT [0:9] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

endpackage

/* rtl/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 4
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;	// counts down to zero, then reloads

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= CW'(DIV - 1);
			o_tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt    <= CW'(DIV - 1);
			o_tick <= 1'b1;	// single-cycle enable
		end else begin
			cnt    <= cnt - 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

/* rtl/key_ctrl.sv */
`timescale 1ns/1ps

module key_ctrl import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  key_t  i_keys,
	input  logic  i_key_tick,
	output mode_e o_mode,
	output pos_e  o_pos,
	output logic  o_alarm_en,
	output logic  o_inc
);

	key_t key_cur;	// sample taken at the last key tick
	key_t key_prev;	// the one before
	key_t key_rise;

	// --------------------
	// key sampling
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			key_cur  <= '0;
			key_prev <= '0;
		end else if (i_key_tick) begin
			key_cur  <= i_keys;
			key_prev <= key_cur;
		end
	end

	// stays valid for one whole key tick period
	assign key_rise = key_cur & ~key_prev;

	// --------------------
	// mode, position and alarm enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= MODE_CLOCK;
			o_pos      <= POS_SEC;
			o_alarm_en <= 1'b0;
			o_inc      <= 1'b0;
		end else begin
			o_inc <= i_key_tick & key_rise.inc;
			if (i_key_tick) begin
				if (key_rise.mode) begin
					case (o_mode)
						MODE_CLOCK: o_mode <= MODE_SETUP;
						MODE_SETUP: o_mode <= MODE_ALARM;
						default:    o_mode <= MODE_CLOCK;
					endcase
				end
				if (key_rise.pos) begin
					case (o_pos)
						POS_SEC: o_pos <= POS_MIN;
						POS_MIN: o_pos <= POS_HR;
						default: o_pos <= POS_SEC;
					endcase
				end
				if (key_rise.alarm) begin
					o_alarm_en <= ~o_alarm_en;
				end
			end
		end
	end

	// mode must stay on one of the three real modes
	a_mode_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		o_mode inside {MODE_CLOCK, MODE_SETUP, MODE_ALARM}
	);

endmodule

/* rtl/timekeeper.sv */
`timescale 1ns/1ps

module timekeeper import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_sec_tick,
	input  logic  i_inc,
	input  mode_e i_mode,
	input  pos_e  i_pos,
	input  logic  i_alarm_en,
	output hms_t  o_time,
	output hms_t  o_alarm_time,
	output logic  o_alarm
);

	hms_t time_nxt;
	hms_t alarm_nxt;

	// wraps to zero past the field maximum
	function automatic logic [5:0] next_val(input logic [5:0] v, input logic [5:0] max_v);
		return (v >= max_v) ? 6'd0 : v + 6'd1;
	endfunction

	// one second forward with carries
	function automatic hms_t advance(input hms_t t);
		hms_t       r;
		logic [5:0] hr_n;
		r     = t;
		hr_n  = next_val({1'b0, t.hr}, {1'b0, MAX_HR});
		r.sec = next_val(t.sec, MAX_SEC);
		if (t.sec == MAX_SEC) begin
			r.min = next_val(t.min, MAX_MIN);
			if (t.min == MAX_MIN) begin
				r.hr = hr_n[4:0];
			end
		end
		return r;
	endfunction

	// step a single field, no carry into the next one
	function automatic hms_t step_field(input hms_t t, input pos_e p);
		hms_t       r;
		logic [5:0] hr_n;
		r    = t;
		hr_n = next_val({1'b0, t.hr}, {1'b0, MAX_HR});
		case (p)
			POS_SEC: r.sec = next_val(t.sec, MAX_SEC);
			POS_MIN: r.min = next_val(t.min, MAX_MIN);
			POS_HR:  r.hr  = hr_n[4:0];
			default: r     = t;
		endcase
		return r;
	endfunction

	// --------------------
	// next-state selection
	always_comb begin
		time_nxt  = o_time;
		alarm_nxt = o_alarm_time;
		if (i_sec_tick && i_mode != MODE_SETUP) begin
			time_nxt = advance(o_time);	// frozen while setting
		end
		if (i_inc) begin
			case (i_mode)
				MODE_SETUP: time_nxt  = step_field(o_time, i_pos);
				MODE_ALARM: alarm_nxt = step_field(o_alarm_time, i_pos);
				default:    ;	// clock mode ignores inc
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time       <= '0;
			o_alarm_time <= '0;
			o_alarm      <= 1'b0;
		end else begin
			o_time       <= time_nxt;
			o_alarm_time <= alarm_nxt;
			// latched until the enable drops
			o_alarm      <= i_alarm_en & (o_alarm | (o_time == o_alarm_time));
		end
	end

	a_fields_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		o_time.sec <= MAX_SEC && o_time.min <= MAX_MIN && o_time.hr <= MAX_HR &&
		o_alarm_time.sec <= MAX_SEC && o_alarm_time.min <= MAX_MIN &&
		o_alarm_time.hr <= MAX_HR
	);

endmodule

/* rtl/digit_encoder.sv */
`timescale 1ns/1ps

module digit_encoder import clock_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mode_e                  i_mode,
	input  pos_e                   i_pos,
	input  hms_t                   i_time,
	input  hms_t                   i_alarm_time,
	input  logic                   i_blink_tick,
	output seg_t [NUM_DIGITS-1:0]  o_digit_segs
);

	hms_t                        shown;
	logic                        blink_on;	// 0 = selected field dark
	logic [NUM_DIGITS-1:0]       blank_mask;
	logic [NUM_DIGITS-1:0][3:0]  digit_val;

	// {tens, ones} of a value below 60
	function automatic logic [7:0] split2(input logic [5:0] v);
		logic [5:0] tens;
		logic [5:0] ones;
		tens = v / 6'd10;
		ones = v % 6'd10;
		return {tens[3:0], ones[3:0]};
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blink_on <= 1'b1;
		end else if (i_blink_tick) begin
			blink_on <= ~blink_on;
		end
	end

	assign shown     = (i_mode == MODE_ALARM) ? i_alarm_time : i_time;
	assign digit_val = {split2({1'b0, shown.hr}), split2(shown.min), split2(shown.sec)};

	// --------------------
	// blanking and decode
	always_comb begin
		case (i_pos)
			POS_SEC: blank_mask = 6'b00_00_11;
			POS_MIN: blank_mask = 6'b00_11_00;
			POS_HR:  blank_mask = 6'b11_00_00;
			default: blank_mask = '0;
		endcase
		if (i_mode == MODE_CLOCK || blink_on) begin
			blank_mask = '0;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_DIGITS; i++) begin
			if (blank_mask[i]) begin
				o_digit_segs[i] = SEG_BLANK;
			end else begin
				o_digit_segs[i] = SEG_DIGIT[digit_val[i]];
			end
		end
	end

endmodule

/* rtl/scan_driver.sv */
`timescale 1ns/1ps

module scan_driver import clock_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_scan_tick,
	input  seg_t [NUM_DIGITS-1:0]  i_digit_segs,
	output seg_t                   o_seg,
	output logic [NUM_DIGITS-1:0]  o_seg_enb
);

	localparam int                    IW      = $clog2(NUM_DIGITS);
	localparam logic [NUM_DIGITS-1:0] ONE_HOT = 1;

	logic [IW-1:0] idx;	// digit being driven

	// --------------------
	// scan index
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (i_scan_tick) begin
			if (idx == IW'(NUM_DIGITS - 1)) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// enable and pattern change on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= SEG_BLANK;
			o_seg_enb <= ~ONE_HOT;	// digit 0
		end else begin
			o_seg     <= i_digit_segs[idx];
			o_seg_enb <= ~(ONE_HOT << idx);
		end
	end

	a_one_digit: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb)
	);

endmodule

/* rtl/clock_top.sv */
`timescale 1ns/1ps

module clock_top import clock_pkg::*; #(
	parameter int CLK_PER_SEC = 50_000_000,
	parameter int KEY_DIV     = 500_000,
	parameter int SCAN_DIV    = 25_000,
	parameter int BLINK_DIV   = 12_500_000
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  key_t                   i_keys,
	output seg_t                   o_seg,
	output logic [NUM_DIGITS-1:0]  o_seg_enb,
	output logic                   o_alarm
);

	logic                  sec_tick;
	logic                  key_tick;
	logic                  scan_tick;
	logic                  blink_tick;
	mode_e                 mode;
	pos_e                  pos;
	logic                  alarm_en;
	logic                  inc_pulse;
	hms_t                  time_now;
	hms_t                  alarm_time;
	seg_t [NUM_DIGITS-1:0] digit_segs;

	// --------------------
	// enable ticks
	tick_gen #(.DIV(CLK_PER_SEC)) sec_tick_i (.clk, .rst_n, .o_tick(sec_tick));
	tick_gen #(.DIV(KEY_DIV))     key_tick_i (.clk, .rst_n, .o_tick(key_tick));
	tick_gen #(.DIV(SCAN_DIV))    scan_tick_i (.clk, .rst_n, .o_tick(scan_tick));
	tick_gen #(.DIV(BLINK_DIV))   blink_tick_i (.clk, .rst_n, .o_tick(blink_tick));

	key_ctrl key_ctrl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_keys     (i_keys),
		.i_key_tick (key_tick),
		.o_mode     (mode),
		.o_pos      (pos),
		.o_alarm_en (alarm_en),
		.o_inc      (inc_pulse)
	);

	timekeeper timekeeper_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_sec_tick   (sec_tick),
		.i_inc        (inc_pulse),
		.i_mode       (mode),
		.i_pos        (pos),
		.i_alarm_en   (alarm_en),
		.o_time       (time_now),
		.o_alarm_time (alarm_time),
		.o_alarm      (o_alarm)
	);

	// --------------------
	// display path
	digit_encoder digit_encoder_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_mode       (mode),
		.i_pos        (pos),
		.i_time       (time_now),
		.i_alarm_time (alarm_time),
		.i_blink_tick (blink_tick),
		.o_digit_segs (digit_segs)
	);

	scan_driver scan_driver_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan_tick  (scan_tick),
		.i_digit_segs (digit_segs),
		.o_seg        (o_seg),
		.o_seg_enb    (o_seg_enb)
	);

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk   = 1'b0;
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;	// released between rising edges
	end

	always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

/* sim/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [6:0] i_seg,
	input  logic [5:0] i_seg_enb,
	input  logic       i_alarm,
	input  logic       i_check_en,
	input  logic [4:0] i_exp_hr,
	input  logic [5:0] i_exp_min,
	input  logic [5:0] i_exp_sec_lo,
	input  logic [5:0] i_exp_sec_hi,
	input  logic       i_exp_alarm,
	input  logic [5:0] i_blank_ok,
	output int         o_errors,
	output int         o_scans
);

	// reference patterns {a..g}, digits 0 to 9
	localparam logic [6:0] SEG_REF [0:9] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

	int         cap [0:5];	// 0-9 digit, 10 blank, 15 unknown
	logic [5:0] seen;
	int         prev_idx;

	function automatic int seg_to_digit(input logic [6:0] s);
		int r;
		r = 15;
		if (s == 7'b000_0000) r = 10;
		for (int i = 0; i < 10; i++) begin
			if (s == SEG_REF[i]) r = i;
		end
		return r;
	endfunction

	task automatic evaluate_scan;
		int sec_v;
		int min_v;
		int hr_v;
		bit bad;
		bad   = 0;
		sec_v = cap[1] * 10 + cap[0];
		min_v = cap[3] * 10 + cap[2];
		hr_v  = cap[5] * 10 + cap[4];
		for (int d = 0; d < 6; d++) begin
			if (cap[d] == 15) begin
				$display("at %0t ns digit %0d showed a pattern that is neither a digit nor blank",
					$time, d);
				o_errors++;
				bad = 1;
			end else if (cap[d] == 10 && !i_blank_ok[d]) begin
				$display("CHECK FAILED at %0t ns: digit %0d blank but should be lit", $time, d);
				o_errors++;
				bad = 1;
			end
		end
		if (!bad) begin
			// a blank digit makes its field a wildcard
			if (cap[0] < 10 && cap[1] < 10 && (sec_v < i_exp_sec_lo || sec_v > i_exp_sec_hi)) begin
				$display("CHECK FAILED at %0t ns: seconds %02d outside %02d..%02d",
					$time, sec_v, i_exp_sec_lo, i_exp_sec_hi);
				o_errors++;
			end
			if (cap[2] < 10 && cap[3] < 10 && min_v != i_exp_min) begin
				$display("CHECK FAILED at %0t ns: minutes %02d, expected %02d",
					$time, min_v, i_exp_min);
				o_errors++;
			end
			if (cap[4] < 10 && cap[5] < 10 && hr_v != i_exp_hr) begin
				$display("CHECK FAILED at %0t ns: hours %02d, expected %02d",
					$time, hr_v, i_exp_hr);
				o_errors++;
			end
		end
		if (i_alarm !== i_exp_alarm) begin
			$display("CHECK FAILED at %0t ns: alarm %b, expected %b", $time, i_alarm, i_exp_alarm);
			o_errors++;
		end
		o_scans++;
	endtask

	// --------------------
	// sampled on the rising edge, before the DUT registers update
	initial begin
		o_errors = 0;
		o_scans  = 0;
		seen     = '0;
		prev_idx = 0;
	end

	always @(posedge clk) begin
		int idx;
		idx = 0;
		if (rst_n) begin
			if (!$onehot(~i_seg_enb)) begin
				$display("CHECK FAILED at %0t ns: digit enables %b not one-hot low", $time, i_seg_enb);
				o_errors++;
			end
			for (int i = 0; i < 6; i++) begin
				if (!i_seg_enb[i]) idx = i;
			end
			if (!i_check_en) begin
				seen = '0;
			end else begin
				if (idx == 0 && prev_idx == 5) begin
					if (seen == 6'b11_1111) evaluate_scan();	// partial scans dropped
					seen = '0;
				end
				cap[idx]  = seg_to_digit(i_seg);
				seen[idx] = 1'b1;
			end
			prev_idx = idx;
		end
	end

endmodule

/* sim/tb_clock_top.sv */
`timescale 1ns/1ps

module tb_clock_top import clock_pkg::*;;

	localparam int CLK_PER_SEC = 2000;
	localparam int KEY_DIV     = 4;
	localparam int SCAN_DIV    = 4;
	localparam int BLINK_DIV   = 64;
	localparam int PRESS_CYC   = 6 * KEY_DIV;		// held 3 periods, released 3
	localparam int SETTLE_CYC  = 4 * KEY_DIV + 8;
	localparam int WINDOW_CYC  = 6 * NUM_DIGITS * SCAN_DIV;	// six full scans

	localparam logic [3:0] K_NONE  = 4'b0000;
	localparam logic [3:0] K_MODE  = 4'b1000;
	localparam logic [3:0] K_POS   = 4'b0100;
	localparam logic [3:0] K_INC   = 4'b0010;
	localparam logic [3:0] K_ALARM = 4'b0001;
	localparam logic [5:0] B_NONE  = 6'b00_00_00;
	localparam logic [5:0] B_SEC   = 6'b00_00_11;
	localparam logic [5:0] B_MIN   = 6'b00_11_00;
	localparam logic [5:0] B_HR    = 6'b11_00_00;

	typedef struct packed {
		logic [3:0] key;
		logic [7:0] presses;
		logic [3:0] wait_s;
		logic       hold;	// also check during the wait
		logic [4:0] hr;
		logic [5:0] min;
		logic [5:0] sec_lo;
		logic [5:0] sec_hi;
		logic       alarm;
		logic [5:0] blank;
	} row_t;

	logic       clk;
	logic       rst_n;
	key_t       keys;
	seg_t       seg;
	logic [5:0] seg_enb;
	logic       alarm;
	row_t       cur;
	logic       check_en;
	int         chk_errors;
	int         scans;
	int         tb_errors;
	int         limit;
	bit         limit_ready;
	row_t       rows[$];

	tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) clk_gen_i (.o_clk(clk), .o_rst_n(rst_n));

	clock_top #(
		.CLK_PER_SEC (CLK_PER_SEC),
		.KEY_DIV     (KEY_DIV),
		.SCAN_DIV    (SCAN_DIV),
		.BLINK_DIV   (BLINK_DIV)
	) dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_keys    (keys),
		.o_seg     (seg),
		.o_seg_enb (seg_enb),
		.o_alarm   (alarm)
	);

	tb_checker checker_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_seg        (seg),
		.i_seg_enb    (seg_enb),
		.i_alarm      (alarm),
		.i_check_en   (check_en),
		.i_exp_hr     (cur.hr),
		.i_exp_min    (cur.min),
		.i_exp_sec_lo (cur.sec_lo),
		.i_exp_sec_hi (cur.sec_hi),
		.i_exp_alarm  (cur.alarm),
		.i_blank_ok   (cur.blank),
		.o_errors     (chk_errors),
		.o_scans      (scans)
	);

	function automatic row_t make_row(input logic [3:0] key, input int n, input int w,
		input bit hold, input int hr, input int mn, input int lo, input int hi,
		input bit al, input logic [5:0] blank);
		row_t r;
		r = '{key: key, presses: 8'(n), wait_s: 4'(w), hold: hold, hr: 5'(hr), min: 6'(mn),
			sec_lo: 6'(lo), sec_hi: 6'(hi), alarm: al, blank: blank};
		return r;
	endfunction

	task automatic press_key(input logic [3:0] code);
		keys = key_t'(code);
		repeat (PRESS_CYC / 2) @(negedge clk);
		keys = '0;
		repeat (PRESS_CYC / 2) @(negedge clk);
	endtask

	task automatic apply_row(input row_t r);
		int scans0;
		cur      = r;
		check_en = 1'b0;
		for (int i = 0; i < r.presses; i++) press_key(r.key);
		repeat (SETTLE_CYC) @(negedge clk);
		check_en = r.hold;
		repeat (r.wait_s * CLK_PER_SEC) @(negedge clk);
		check_en = 1'b1;
		scans0   = scans;
		repeat (WINDOW_CYC) @(negedge clk);
		check_en = 1'b0;
		if (scans == scans0) begin
			$display("no complete display scan was seen at %0t ns", $time);
			tb_errors++;
		end
	endtask

	// --------------------
	// watchdog
	initial begin
		wait (limit_ready);
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Checks failed");
		$finish;
	end

	initial begin
		keys        = '0;
		check_en    = 1'b0;
		cur         = '0;
		tb_errors   = 0;
		limit_ready = 0;
		// key, presses, wait s, hold, hr, min, sec lo..hi, alarm, blankable digits
		rows.push_back(make_row(K_NONE,  0, 0, 0,  0,  0,  0,  0, 0, B_NONE));
		rows.push_back(make_row(K_MODE,  1, 0, 0,  0,  0,  0,  0, 0, B_SEC));	// setup
		rows.push_back(make_row(K_INC,  56, 0, 0,  0,  0, 56, 56, 0, B_SEC));
		rows.push_back(make_row(K_POS,   1, 0, 0,  0,  0, 56, 56, 0, B_MIN));
		rows.push_back(make_row(K_INC,  34, 0, 0,  0, 34, 56, 56, 0, B_MIN));
		rows.push_back(make_row(K_POS,   1, 0, 0,  0, 34, 56, 56, 0, B_HR));
		rows.push_back(make_row(K_INC,  12, 0, 0, 12, 34, 56, 56, 0, B_HR));
		rows.push_back(make_row(K_NONE,  0, 2, 1, 12, 34, 56, 56, 0, B_HR));	// frozen
		rows.push_back(make_row(K_POS,   1, 0, 0, 12, 34, 56, 56, 0, B_SEC));
		rows.push_back(make_row(K_INC,   4, 0, 0, 12, 34,  0,  0, 0, B_SEC));	// wraps
		rows.push_back(make_row(K_INC,  59, 0, 0, 12, 34, 59, 59, 0, B_SEC));
		rows.push_back(make_row(K_POS,   1, 0, 0, 12, 34, 59, 59, 0, B_MIN));
		rows.push_back(make_row(K_INC,  25, 0, 0, 12, 59, 59, 59, 0, B_MIN));
		rows.push_back(make_row(K_POS,   1, 0, 0, 12, 59, 59, 59, 0, B_HR));
		rows.push_back(make_row(K_INC,  11, 0, 0, 23, 59, 59, 59, 0, B_HR));
		rows.push_back(make_row(K_MODE,  2, 1, 0,  0,  0,  0,  2, 0, B_NONE));	// midnight
		rows.push_back(make_row(K_MODE,  2, 0, 0,  0,  0,  0,  0, 0, B_HR));	// alarm view
		rows.push_back(make_row(K_POS,   1, 0, 0,  0,  0,  0,  0, 0, B_SEC));
		rows.push_back(make_row(K_INC,   3, 0, 0,  0,  0,  3,  3, 0, B_SEC));
		rows.push_back(make_row(K_ALARM, 1, 0, 0,  0,  0,  3,  3, 0, B_SEC));
		rows.push_back(make_row(K_MODE,  1, 4, 0,  0,  0,  5,  9, 1, B_NONE));
		rows.push_back(make_row(K_ALARM, 1, 0, 0,  0,  0,  5,  9, 0, B_NONE));

		limit = 20 + 5000;
		foreach (rows[i]) begin
			limit += rows[i].presses * PRESS_CYC + SETTLE_CYC + WINDOW_CYC;
			limit += rows[i].wait_s * CLK_PER_SEC;
		end
		limit_ready = 1;

		wait (rst_n);
		@(negedge clk);
		foreach (rows[i]) apply_row(rows[i]);

		$display("errors: %0d (checker %0d, testbench %0d)",
			chk_errors + tb_errors, chk_errors, tb_errors);
		if (chk_errors + tb_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* digital_clock.f */
rtl/clock_pkg.sv
rtl/tick_gen.sv
rtl/key_ctrl.sv
rtl/timekeeper.sv
rtl/digit_encoder.sv
rtl/scan_driver.sv
rtl/clock_top.sv
sim/tb_clk_gen.sv
sim/tb_checker.sv
sim/tb_clock_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the digital clock testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_clock_top \
	-f digital_clock.f \
	-o Vtb_clock_top

out=$(./obj_dir/Vtb_clock_top)
echo "$out"

if grep -q "All checks passed" <<< "$out"; then
	exit 0
else
	exit 1
fi
